// File: logic/bram_pkg.sv
`default_nettype none

package bram_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data word
  localparam int WORD_WIDTH = 32;

  // CPU word address, wide enough for the largest supported RAM
  localparam int CPU_ADDR_WIDTH = 10;

  // Words in the RAM unless the top level is given another depth
  localparam int DEFAULT_MEM_DEPTH = 256;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [WORD_WIDTH-1:0] word_t;

  typedef logic [CPU_ADDR_WIDTH-1:0] cpu_addr_t;

  // Scan port FSM
  typedef enum logic {
    SCAN_IDLE,
    SCAN_RUN
  } scan_state_e;

endpackage

`default_nettype wire

// File: logic/cpu_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_req_stage #(
  parameter int MEM_DEPTH = bram_pkg::DEFAULT_MEM_DEPTH
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  input  wire logic                      read,
  input  wire logic                      write,
  input  wire bram_pkg::cpu_addr_t       address,
  input  wire bram_pkg::word_t           write_data,

  output logic                           req_valid,
  output logic                           req_write,
  output logic [$clog2(MEM_DEPTH)-1:0]   req_addr,
  output bram_pkg::word_t                req_data,
  output logic                           req_bad_addr,
  output logic                           req_bad_access
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  // One bit wider than the CPU address so a full 1024 word RAM still fits
  localparam logic [bram_pkg::CPU_ADDR_WIDTH:0] ADDR_LIMIT =
    (bram_pkg::CPU_ADDR_WIDTH + 1)'(MEM_DEPTH);

  logic strobe;
  logic in_range;

  assign strobe   = read | write;
  assign in_range = {1'b0, address} < ADDR_LIMIT;

  ////////////////////////////////////////////////////////////
  // Request flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid      <= 1'b0;
      req_write      <= 1'b0;
      req_bad_addr   <= 1'b0;
      req_bad_access <= 1'b0;
    end else begin
      req_valid <= strobe;
      // Only a legal in-range write may reach the RAM
      req_write      <= write && !read && in_range;
      req_bad_addr   <= strobe && !in_range;
      req_bad_access <= read && write;
    end
  end

  // Address and data follow the strobe
  always_ff @(posedge clk) begin
    req_addr <= address[IDX_W-1:0];
    req_data <= write_data;
  end

endmodule

`default_nettype wire

// File: logic/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter int MEM_DEPTH = bram_pkg::DEFAULT_MEM_DEPTH
) (
  input  wire logic                         clk,

  // Port A reads and writes
  input  wire logic                         wen_a,
  input  wire logic [$clog2(MEM_DEPTH)-1:0] addr_a,
  input  wire bram_pkg::word_t              din_a,
  output bram_pkg::word_t                   dout_a,

  // Port B reads only
  input  wire logic [$clog2(MEM_DEPTH)-1:0] addr_b,
  output bram_pkg::word_t                   dout_b
);

  bram_pkg::word_t mem [0:MEM_DEPTH-1];

  ////////////////////////////////////////////////////////////
  // Port A
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wen_a) begin
      mem[addr_a] <= din_a;
    end
  end

  // Read before write on the same port
  always_ff @(posedge clk) begin
    dout_a <= mem[addr_a];
  end

  ////////////////////////////////////////////////////////////
  // Port B
  ////////////////////////////////////////////////////////////

  // A write to the same address in this cycle still returns the old word
  always_ff @(posedge clk) begin
    dout_b <= mem[addr_b];
  end

endmodule

`default_nettype wire

// File: logic/cpu_resp_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_resp_stage (
  input  wire logic            clk,
  input  wire logic            rst_n,

  input  wire logic            req_valid,
  input  wire logic            req_write,
  input  wire logic            req_bad_addr,
  input  wire logic            req_bad_access,
  input  wire bram_pkg::word_t dout_a,

  output logic                 access_complete,
  output bram_pkg::word_t      read_data,
  output logic                 invalid_address,
  output logic                 invalid_access
);

  // Request flags while the RAM performs the access
  logic mem_valid;
  logic mem_write;
  logic mem_bad_addr;
  logic mem_bad_access;
  logic legal_read;

  assign legal_read = mem_valid && !mem_write && !mem_bad_addr && !mem_bad_access;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_valid       <= 1'b0;
      mem_write       <= 1'b0;
      mem_bad_addr    <= 1'b0;
      mem_bad_access  <= 1'b0;
      access_complete <= 1'b0;
      invalid_address <= 1'b0;
      invalid_access  <= 1'b0;
    end else begin
      mem_valid       <= req_valid;
      mem_write       <= req_write;
      mem_bad_addr    <= req_bad_addr;
      mem_bad_access  <= req_bad_access;
      access_complete <= mem_valid;
      invalid_address <= mem_bad_addr;
      invalid_access  <= mem_bad_access;
    end
  end

  // Zero on writes, errors and idle cycles
  always_ff @(posedge clk) begin
    read_data <= legal_read ? dout_a : '0;
  end

endmodule

`default_nettype wire

// File: logic/scan_reader.sv
`timescale 1ns/1ps
`default_nettype none

module scan_reader #(
  parameter int MEM_DEPTH = bram_pkg::DEFAULT_MEM_DEPTH
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,

  input  wire logic                      scan_start,
  input  wire bram_pkg::cpu_addr_t       scan_base,
  input  wire bram_pkg::cpu_addr_t       scan_len,
  input  wire bram_pkg::word_t           dout_b,

  output logic [$clog2(MEM_DEPTH)-1:0]   addr_b,
  output logic                           scan_valid,
  output bram_pkg::word_t                scan_data,
  output logic                           scan_done,
  output logic                           scan_busy
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  bram_pkg::scan_state_e state;
  bram_pkg::cpu_addr_t   remaining;

  logic load;
  logic issue;
  logic issue_last;
  logic pipe_valid;
  logic pipe_last;

  // Start is only taken while idle
  assign load       = (state == bram_pkg::SCAN_IDLE) && scan_start && (scan_len != '0);
  assign issue      = (state == bram_pkg::SCAN_RUN);
  assign issue_last = issue && (remaining == bram_pkg::cpu_addr_t'(1));
  assign scan_busy  = issue;

  ////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= bram_pkg::SCAN_IDLE;
    end else begin
      case (state)
        bram_pkg::SCAN_IDLE: begin
          if (load) begin
            state <= bram_pkg::SCAN_RUN;
          end
        end
        bram_pkg::SCAN_RUN: begin
          if (issue_last) begin
            state <= bram_pkg::SCAN_IDLE;
          end
        end
        default: state <= bram_pkg::SCAN_IDLE;
      endcase
    end
  end

  // Address counter wraps at the RAM depth
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_b <= '0;
    end else if (load) begin
      addr_b <= scan_base[IDX_W-1:0];
    end else if (issue) begin
      addr_b <= addr_b + IDX_W'(1);
    end
  end

  // Words still to issue
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (load) begin
      remaining <= scan_len;
    end else if (issue) begin
      remaining <= remaining - bram_pkg::cpu_addr_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Valid and last pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_valid <= 1'b0;
      pipe_last  <= 1'b0;
      scan_valid <= 1'b0;
      scan_done  <= 1'b0;
    end else begin
      pipe_valid <= issue;
      pipe_last  <= issue_last;
      scan_valid <= pipe_valid;
      scan_done  <= pipe_last;
    end
  end

  always_ff @(posedge clk) begin
    scan_data <= dout_b;
  end

endmodule

`default_nettype wire

// File: logic/cpu_bram_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bram_top #(
  parameter int MEM_DEPTH = bram_pkg::DEFAULT_MEM_DEPTH
) (
  input  wire logic                clk,
  input  wire logic                rst_n,

  // CPU port
  input  wire logic                read,
  input  wire logic                write,
  input  wire bram_pkg::cpu_addr_t address,
  input  wire bram_pkg::word_t     write_data,
  output wire logic                access_complete,
  output wire bram_pkg::word_t     read_data,
  output wire logic                invalid_address,
  output wire logic                invalid_access,

  // Scan port
  input  wire logic                scan_start,
  input  wire bram_pkg::cpu_addr_t scan_base,
  input  wire bram_pkg::cpu_addr_t scan_len,
  output wire logic                scan_valid,
  output wire bram_pkg::word_t     scan_data,
  output wire logic                scan_done,
  output wire logic                scan_busy
);

  localparam int IDX_W = $clog2(MEM_DEPTH);

  logic             req_valid;
  logic             req_write;
  logic [IDX_W-1:0] req_addr;
  bram_pkg::word_t  req_data;
  logic             req_bad_addr;
  logic             req_bad_access;
  bram_pkg::word_t  dout_a;
  logic [IDX_W-1:0] addr_b;
  bram_pkg::word_t  dout_b;

  ////////////////////////////////////////////////////////////
  // CPU pipeline
  ////////////////////////////////////////////////////////////

  cpu_req_stage #(
    .MEM_DEPTH      (MEM_DEPTH)
  ) req_stage_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .read           (read),
    .write          (write),
    .address        (address),
    .write_data     (write_data),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .req_bad_addr   (req_bad_addr),
    .req_bad_access (req_bad_access)
  );

  sdp_ram #(
    .MEM_DEPTH (MEM_DEPTH)
  ) ram_i (
    .clk       (clk),
    .wen_a     (req_write),
    .addr_a    (req_addr),
    .din_a     (req_data),
    .dout_a    (dout_a),
    .addr_b    (addr_b),
    .dout_b    (dout_b)
  );

  cpu_resp_stage resp_stage_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid       (req_valid),
    .req_write       (req_write),
    .req_bad_addr    (req_bad_addr),
    .req_bad_access  (req_bad_access),
    .dout_a          (dout_a),
    .access_complete (access_complete),
    .read_data       (read_data),
    .invalid_address (invalid_address),
    .invalid_access  (invalid_access)
  );

  // Scan stage on the read-only port
  scan_reader #(
    .MEM_DEPTH  (MEM_DEPTH)
  ) scan_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .scan_start (scan_start),
    .scan_base  (scan_base),
    .scan_len   (scan_len),
    .dout_b     (dout_b),
    .addr_b     (addr_b),
    .scan_valid (scan_valid),
    .scan_data  (scan_data),
    .scan_done  (scan_done),
    .scan_busy  (scan_busy)
  );

endmodule

`default_nettype wire

// File: tb/cpu_bram_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bram_chk #(
  parameter int MEM_DEPTH = bram_pkg::DEFAULT_MEM_DEPTH
) (
  input wire logic                clk,
  input wire logic                rst_n,
  input wire logic                read,
  input wire logic                write,
  input wire bram_pkg::cpu_addr_t address,
  input wire bram_pkg::word_t     write_data,
  input wire logic                access_complete,
  input wire bram_pkg::word_t     read_data,
  input wire logic                invalid_address,
  input wire logic                invalid_access,
  input wire logic                scan_start,
  input wire bram_pkg::cpu_addr_t scan_base,
  input wire bram_pkg::cpu_addr_t scan_len,
  input wire logic                scan_valid,
  input wire bram_pkg::word_t     scan_data,
  input wire logic                scan_done,
  input wire logic                scan_busy
);

  localparam int IDX_W  = $clog2(MEM_DEPTH);
  localparam int RESP_W = bram_pkg::WORD_WIDTH + 3;

  // Failure count that the testbench reads
  int fail_count = 0;

  // Shadow RAM takes each legal write one edge after its strobe as the RAM does
  bram_pkg::word_t     shadow [0:MEM_DEPTH-1];
  logic [2:0]          req_flags;
  logic                req_wr;
  logic [IDX_W-1:0]    req_idx;
  bram_pkg::word_t     req_wdata;
  logic [2:0]          rsp_flags [0:1];
  bram_pkg::word_t     rsp_data [0:1];
  logic                scan_on;
  logic [IDX_W-1:0]    scan_idx;
  bram_pkg::cpu_addr_t scan_left;
  logic [1:0]          word_valid;
  logic [1:0]          word_last;
  bram_pkg::word_t     word_data [0:1];
  logic                strobe;
  logic                in_range;
  logic [RESP_W-1:0]   cpu_exp;
  logic [RESP_W-1:0]   cpu_got;
  logic [RESP_W-1:0]   scan_exp;
  logic [RESP_W-1:0]   scan_got;

  assign strobe   = read | write;
  assign in_range = int'(address) < MEM_DEPTH;

  always @(posedge clk) begin
    if (!rst_n) begin
      req_flags    <= '0;
      req_wr       <= 1'b0;
      rsp_flags[0] <= '0;
      rsp_flags[1] <= '0;
      rsp_data[0]  <= '0;
      rsp_data[1]  <= '0;
      scan_on      <= 1'b0;
      word_valid   <= '0;
      word_last    <= '0;
    end else begin
      // Valid, bad address, bad access
      req_flags <= {strobe, strobe && !in_range, read && write};
      req_wr    <= write && !read && in_range;
      req_idx   <= address[IDX_W-1:0];
      req_wdata <= write_data;
      if (req_wr) begin
        shadow[req_idx] <= req_wdata;
      end
      rsp_flags[0] <= req_flags;
      rsp_data[0]  <= (req_flags == 3'b100 && !req_wr) ? shadow[req_idx] : '0;
      rsp_flags[1] <= rsp_flags[0];
      rsp_data[1]  <= rsp_data[0];
      // Scan model drops a start while busy
      if (!scan_on && scan_start && scan_len != '0) begin
        scan_on   <= 1'b1;
        scan_idx  <= scan_base[IDX_W-1:0];
        scan_left <= scan_len;
      end else if (scan_on) begin
        scan_on   <= scan_left != bram_pkg::cpu_addr_t'(1);
        scan_idx  <= scan_idx + 1'b1;
        scan_left <= scan_left - 1'b1;
      end
      word_valid   <= {word_valid[0], scan_on};
      word_last    <= {word_last[0], scan_on && scan_left == bram_pkg::cpu_addr_t'(1)};
      word_data[0] <= shadow[scan_idx];
      word_data[1] <= word_data[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  assign cpu_exp  = {rsp_flags[1], rsp_data[1]};
  assign cpu_got  = {access_complete, invalid_address, invalid_access, read_data};
  assign scan_exp = {word_valid[1], word_valid[1] && word_last[1], scan_on,
                     word_valid[1] ? word_data[1] : bram_pkg::word_t'(0)};
  assign scan_got = {scan_valid, scan_done, scan_busy,
                     scan_valid ? scan_data : bram_pkg::word_t'(0)};

  // Response three edges after the strobe is sampled and low when idle
  cpu_response: assert property (@(posedge clk) disable iff (!rst_n) cpu_got === cpu_exp)
    else begin
      fail_count++;
      $error("Fail cpu response: expected %h actual %h",
             $sampled(cpu_exp), $sampled(cpu_got));
    end

  scan_output: assert property (@(posedge clk) disable iff (!rst_n) scan_got === scan_exp)
    else begin
      fail_count++;
      $error("Fail scan output: expected %h actual %h",
             $sampled(scan_exp), $sampled(scan_got));
    end

  reset_state: assert property (@(posedge clk) !rst_n |=> !(access_complete ||
      invalid_address || invalid_access || scan_valid || scan_done || scan_busy))
    else begin
      fail_count++;
      $error("Control outputs were not low after reset");
    end

endmodule

bind cpu_bram_top cpu_bram_chk #(
  .MEM_DEPTH (MEM_DEPTH)
) chk_i (.*);

`default_nettype wire

// File: tb/cpu_bram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bram_tb;

  localparam int DEPTH = bram_pkg::DEFAULT_MEM_DEPTH;
  // Run limit in clock cycles
  localparam int MAX_CYCLES = 3000;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                read;
  logic                write;
  bram_pkg::cpu_addr_t address;
  bram_pkg::word_t     write_data;
  logic                access_complete;
  bram_pkg::word_t     read_data;
  logic                invalid_address;
  logic                invalid_access;
  logic                scan_start;
  bram_pkg::cpu_addr_t scan_base;
  bram_pkg::cpu_addr_t scan_len;
  logic                scan_valid;
  bram_pkg::word_t     scan_data;
  logic                scan_done;
  logic                scan_busy;

  int   seed = 54066;
  int   cycles = 0;
  int   timeouts = 0;
  int   used [0:63];
  int   pick;
  int   stride;
  logic rd;

  cpu_bram_top #(
    .MEM_DEPTH (DEPTH)
  ) dut_i (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      timeouts++;
      $display("timeout: run did not finish");
      finish_run();
    end
  end

  task automatic cpu_access(input logic r, input logic w, input int addr, input int data);
    read       = r;
    write      = w;
    address    = bram_pkg::cpu_addr_t'(addr);
    write_data = bram_pkg::word_t'(data);
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    read  = 1'b0;
    write = 1'b0;
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic start_scan(input int base, input int len);
    scan_base  = bram_pkg::cpu_addr_t'(base);
    scan_len   = bram_pkg::cpu_addr_t'(len);
    scan_start = 1'b1;
    @(posedge clk);
    #1;
    scan_start = 1'b0;
  endtask

  task automatic wait_scan_done();
    while (!scan_done) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_run();
    $display("assertion failures %0d, timeouts %0d", dut_i.chk_i.fail_count, timeouts);
    if (dut_i.chk_i.fail_count == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    rst_n      = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    address    = '0;
    write_data = '0;
    scan_start = 1'b0;
    scan_base  = '0;
    scan_len   = bram_pkg::cpu_addr_t'(1);
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(4);
    // Fill every word first
    for (int i = 0; i < DEPTH; i++) begin
      cpu_access(1'b0, 1'b1, i, $random(seed));
    end
    for (int i = 0; i < 64; i++) begin
      used[i] = $random(seed) & (DEPTH - 1);
      cpu_access(1'b0, 1'b1, used[i], $random(seed));
    end
    // Odd stride visits all 64 entries in a scrambled order
    stride = ($random(seed) | 1) & 63;
    for (int i = 0; i < 64; i++) begin
      cpu_access(1'b1, 1'b0, used[(i * stride) & 63], 0);
    end
    // Out of range, then the aliased in-range word
    for (int i = 0; i < 8; i++) begin
      pick = DEPTH + $unsigned($random(seed)) % ((1 << bram_pkg::CPU_ADDR_WIDTH) - DEPTH);
      cpu_access(1'b0, 1'b1, pick, $random(seed));
      cpu_access(1'b1, 1'b0, pick, 0);
      cpu_access(1'b1, 1'b0, pick % DEPTH, 0);
    end
    // Read and write together
    for (int i = 0; i < 8; i++) begin
      pick = $random(seed) & (DEPTH - 1);
      cpu_access(1'b1, 1'b1, pick, $random(seed));
      cpu_access(1'b1, 1'b0, pick, 0);
    end
    idle_cycles(4);
    start_scan(DEPTH - 5, 12);
    wait_scan_done();
    for (int i = 0; i < 6; i++) begin
      start_scan($random(seed) & (DEPTH - 1), 1 + $unsigned($random(seed)) % 20);
      wait_scan_done();
    end
    // CPU traffic under a scan with a second start while busy
    start_scan($random(seed) & (DEPTH - 1), 20);
    for (int i = 0; i < 16; i++) begin
      rd         = 1'($random(seed) & 1);
      scan_start = (i == 6);
      cpu_access(rd, !rd, $random(seed) & (DEPTH - 1), $random(seed));
    end
    scan_start = 1'b0;
    idle_cycles(1);
    wait_scan_done();
    idle_cycles(4);
    finish_run();
  end

endmodule

`default_nettype wire

// File: project.f
logic/bram_pkg.sv
logic/cpu_req_stage.sv
logic/sdp_ram.sv
logic/cpu_resp_stage.sv
logic/scan_reader.sv
logic/cpu_bram_top.sv
tb/cpu_bram_chk.sv
tb/cpu_bram_tb.sv

// File: Bender.yml
package:
  name: cpu_bram

sources:
  - files:
      - logic/bram_pkg.sv
      - logic/cpu_req_stage.sv
      - logic/sdp_ram.sv
      - logic/cpu_resp_stage.sv
      - logic/scan_reader.sv
      - logic/cpu_bram_top.sv
  - target: simulation
    files:
      - tb/cpu_bram_chk.sv
      - tb/cpu_bram_tb.sv
